//--- Bender.yml
package:
  name: vic_loader

sources:
  - hdl/vic_map_pkg.sv
  - hdl/tape_pkg.sv
  - hdl/prg_loader.sv
  - hdl/cart_rom_loader.sv
  - hdl/tape_streamer.sv
  - hdl/vic_loader_top.sv
  - target: test
    files:
      - tb/vic_loader_props.sv
      - tb/tb_vic_loader.sv

//--- hdl/cart_rom_loader.sv
/*
 * Cartridge (CRT and CT?) and system ROM image writes,
 * plus the mask of loaded 8 KB cartridge blocks
 */
`timescale 1ns/1ps

module cart_rom_loader import vic_map_pkg::*;
(
	input  logic               clk_sys,
	input  logic               reset,

	input  logic               dl_active_i,
	input  logic [7:0]         dl_index_i,
	input  logic               dl_wr_i,
	input  logic [24:0]        dl_addr_i,
	input  logic [CONF_DW-1:0] dl_data_i,
	input  logic [7:0]         dl_ext_i,

	output logic [CONF_AW-1:0] conf_addr_o,
	output logic [CONF_DW-1:0] conf_data_o,
	output logic               conf_wr_o,
	output logic [N_BLK-1:0]   blk_mask_o
);

	logic               dl_active_q;
	logic               rom_sel;
	logic               crt_sel;
	logic               ctx_sel;
	logic               ctx_start;
	logic               in_rom_win;
	logic [CONF_AW-1:0] cart_addr;

	assign rom_sel    = (dl_index_i == IDX_ROM);
	assign crt_sel    = (dl_index_i == IDX_CRT);
	assign ctx_sel    = (dl_index_i == IDX_CTX);
	assign ctx_start  = ~dl_active_q & dl_active_i & ctx_sel;
	assign in_rom_win = (dl_addr_i >= ROM_WIN_LO) && (dl_addr_i < ROM_WIN_HI);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dl_active_q <= 1'b0;
			conf_wr_o   <= 1'b0;
			blk_mask_o  <= '0;
			cart_addr   <= '0;
			conf_addr_o <= '0;
			conf_data_o <= '0;
		end else begin
			dl_active_q <= dl_active_i;
			conf_wr_o   <= 1'b0;

			////////////////////////////////////////////////////////////
			// Cartridge images
			////////////////////////////////////////////////////////////
			if (dl_active_i && (crt_sel || ctx_sel) && dl_wr_i) begin
				// CRT files open with a 2-byte load address
				if (crt_sel && dl_addr_i == 25'd0) begin
					cart_addr[7:0] <= dl_data_i;
				end else if (crt_sel && dl_addr_i == 25'd1) begin
					cart_addr[15:8] <= dl_data_i;
				end else if (cart_addr < CART_LIMIT) begin
					case (cart_addr[15:13])
						3'd0: blk_mask_o[0] <= 1'b1;
						3'd1: blk_mask_o[1] <= 1'b1;
						3'd2: blk_mask_o[2] <= 1'b1;
						3'd3: blk_mask_o[3] <= 1'b1;
						3'd5: blk_mask_o[4] <= 1'b1;
						default: ;
					endcase
					conf_addr_o <= cart_addr;
					conf_data_o <= dl_data_i;
					conf_wr_o   <= 1'b1;
					cart_addr   <= cart_addr + 16'd1;
				end
			end

			// CT? base address comes from the last extension character
			if (ctx_start) begin
				if (dl_ext_i >= "2" && dl_ext_i <= "9") begin
					cart_addr <= {dl_ext_i[3:0], 12'h000};
				end else if (dl_ext_i >= "A" && dl_ext_i <= "B") begin
					cart_addr <= {dl_ext_i[3:0] + 4'd9, 12'h000};
				end
			end

			////////////////////////////////////////////////////////////
			// Only the 16 KB window of the system ROM image is kept
			////////////////////////////////////////////////////////////
			if (dl_active_i && rom_sel && dl_wr_i && in_rom_win) begin
				conf_addr_o <= dl_addr_i[15:0] + ROM_OFFSET;
				conf_data_o <= dl_data_i;
				conf_wr_o   <= 1'b1;
			end
		end
	end

endmodule

//--- hdl/prg_loader.sv
/*
 * PRG loader: load-address parse, data writes below A000
 * and the BASIC end-pointer patch sequence
 */
`timescale 1ns/1ps

module prg_loader import vic_map_pkg::*;
(
	input  logic               clk_sys,
	input  logic               reset,

	input  logic               dl_active_i,
	input  logic [7:0]         dl_index_i,
	input  logic               dl_wr_i,
	input  logic [24:0]        dl_addr_i,
	input  logic [CONF_DW-1:0] dl_data_i,

	output logic [CONF_AW-1:0] conf_addr_o,
	output logic [CONF_DW-1:0] conf_data_o,
	output logic               conf_wr_o
);

	logic               prg_sel;
	logic               dl_active_q;
	logic               dl_done;
	logic [CONF_AW-1:0] run_addr;
	// 0 is idle, odd steps 1..15 issue the pointer writes
	logic [3:0]         seq;
	logic [2:0]         ptr_idx;

	assign prg_sel = (dl_index_i == IDX_PRG);
	assign dl_done = dl_active_q & ~dl_active_i & prg_sel;
	assign ptr_idx = seq[3:1];

	////////////////////////////////////////////////////////////
	// Control state
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dl_active_q <= 1'b0;
			seq         <= 4'd0;
		end else begin
			dl_active_q <= dl_active_i;

			if (dl_active_i && prg_sel) begin
				seq <= 4'd0;
			end else if (dl_done) begin
				seq <= 4'd1;
			end else if (seq != 4'd0) begin
				// Wraps back to idle after step 15
				seq <= seq + 4'd1;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Running address and write bus
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			conf_wr_o   <= 1'b0;
			conf_addr_o <= '0;
			conf_data_o <= '0;
			run_addr    <= '0;
		end else begin
			conf_wr_o <= 1'b0;

			if (dl_active_i && prg_sel && dl_wr_i) begin
				// First two bytes carry the load address
				if (dl_addr_i == 25'd0) begin
					run_addr[7:0] <= dl_data_i;
				end else if (dl_addr_i == 25'd1) begin
					run_addr[15:8] <= dl_data_i;
				end else if (run_addr < PRG_LIMIT) begin
					conf_addr_o <= run_addr;
					conf_data_o <= dl_data_i;
					conf_wr_o   <= 1'b1;
					run_addr    <= run_addr + 16'd1;
				end
			end

			// Odd steps write the end address into the next pointer
			if (seq[0]) begin
				conf_addr_o <= BASIC_PTRS[ptr_idx];
				conf_data_o <= ptr_idx[0] ? run_addr[15:8] : run_addr[7:0];
				conf_wr_o   <= 1'b1;
			end
		end
	end

endmodule

//--- hdl/tape_pkg.sv
/*
 * Tape buffer widths and end-of-play margin
 */
package tape_pkg;

	// Byte address into external memory
	localparam int TAPE_AW = 25;

	// Width of one tape byte
	localparam int TAPE_DW = 8;

	// The cassette FIFO checks for empty one byte early,
	// so play runs one byte past the image
	localparam logic [TAPE_AW-1:0] TAPE_EXTRA = 25'd2;

endpackage

//--- hdl/tape_streamer.sv
/*
 * Tape image store into external memory with host wait,
 * and the play fetch loop that feeds the cassette FIFO
 */
`timescale 1ns/1ps

module tape_streamer
	import vic_map_pkg::*;
	import tape_pkg::*;
(
	input  logic               clk_sys,
	input  logic               reset,

	input  logic               dl_active_i,
	input  logic [7:0]         dl_index_i,
	input  logic               dl_wr_i,
	input  logic [TAPE_AW-1:0] dl_addr_i,
	input  logic [TAPE_DW-1:0] dl_data_i,
	output logic               dl_wait_o,

	input  logic               play_btn_i,
	input  logic               unload_i,

	output logic [TAPE_AW-1:0] mem_addr_o,
	output logic [TAPE_DW-1:0] mem_din_o,
	output logic               mem_we_o,
	output logic               mem_rd_o,
	input  logic [TAPE_DW-1:0] mem_dout_i,
	input  logic               mem_ready_i,

	output logic               fifo_wr_o,
	output logic [TAPE_DW-1:0] fifo_data_o,
	input  logic               fifo_full_i,
	input  logic               fifo_empty_i,

	output logic               tape_play_o
);

	logic               tap_loading;
	logic               tap_rewind;
	logic               tap_loaded;
	logic [TAPE_AW-1:0] play_addr;
	logic [TAPE_AW-1:0] end_addr;
	logic               rd_pend;
	logic               play_btn_q;
	logic               fifo_empty_q;

	assign tap_loading = dl_active_i & (dl_index_i == IDX_TAP);
	assign tap_rewind  = tap_loading | unload_i;
	assign tap_loaded  = (play_addr < end_addr);

	// Host address drives memory while loading, play address otherwise
	assign mem_addr_o = tap_loading ? dl_addr_i : play_addr;

	////////////////////////////////////////////////////////////
	// Store path with wait handshake
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			mem_we_o  <= 1'b0;
			dl_wait_o <= 1'b0;
			mem_din_o <= '0;
		end else begin
			mem_we_o <= 1'b0;
			if (dl_wr_i && tap_loading) begin
				mem_we_o  <= 1'b1;
				mem_din_o <= dl_data_i;
				dl_wait_o <= 1'b1;
			end else if (!mem_we_o && dl_wait_o && mem_ready_i) begin
				dl_wait_o <= 1'b0;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Play state and fetch loop
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			play_addr    <= '0;
			end_addr     <= '0;
			tape_play_o  <= 1'b0;
			mem_rd_o     <= 1'b0;
			fifo_wr_o    <= 1'b0;
			fifo_data_o  <= '0;
			rd_pend      <= 1'b0;
			play_btn_q   <= 1'b0;
			fifo_empty_q <= 1'b0;
		end else begin
			play_btn_q   <= play_btn_i;
			fifo_empty_q <= fifo_empty_i;

			if (tap_rewind) begin
				// Unload leaves an empty tape
				end_addr    <= tap_loading ? dl_addr_i + TAPE_EXTRA : '0;
				play_addr   <= '0;
				tape_play_o <= tap_loading;
				mem_rd_o    <= 1'b0;
				fifo_wr_o   <= 1'b0;
				rd_pend     <= 1'b0;
			end else begin
				if (~play_btn_q & play_btn_i) begin
					tape_play_o <= ~tape_play_o;
				end
				if (~fifo_empty_q & fifo_empty_i) begin
					tape_play_o <= 1'b0;
				end

				mem_rd_o  <= 1'b0;
				fifo_wr_o <= 1'b0;

				// One guard cycle after each strobe before looking at ready
				if (!mem_rd_o && !fifo_wr_o) begin
					if (rd_pend) begin
						if (mem_ready_i) begin
							fifo_data_o <= mem_dout_i;
							fifo_wr_o   <= 1'b1;
							play_addr   <= play_addr + 25'd1;
							rd_pend     <= 1'b0;
						end
					end else if (!fifo_full_i && tap_loaded && !mem_we_o && mem_ready_i) begin
						mem_rd_o <= 1'b1;
						rd_pend  <= 1'b1;
					end
				end
			end
		end
	end

endmodule

//--- hdl/vic_loader_top.sv
/*
 * Loader top level: PRG, cartridge/ROM and tape paths,
 * write-bus merge and the expansion RAM masks for the core
 */
`timescale 1ns/1ps

module vic_loader_top
	import vic_map_pkg::*;
	import tape_pkg::*;
(
	input  logic               clk_sys,
	input  logic               reset,

	input  logic               dl_active_i,
	input  logic [7:0]         dl_index_i,
	input  logic               dl_wr_i,
	input  logic [TAPE_AW-1:0] dl_addr_i,
	input  logic [TAPE_DW-1:0] dl_data_i,
	input  logic [7:0]         dl_ext_i,
	output logic               dl_wait_o,

	input  logic               play_btn_i,
	input  logic               unload_i,
	input  logic [TAPE_DW-1:0] mem_dout_i,
	input  logic               mem_ready_i,
	input  logic               fifo_full_i,
	input  logic               fifo_empty_i,

	input  logic               extram1_i,
	input  logic [1:0]         extram2_sel_i,
	input  logic               extram3_i,
	input  logic               cart_writable_i,

	output logic [CONF_AW-1:0] conf_addr_o,
	output logic [CONF_DW-1:0] conf_data_o,
	output logic               conf_wr_o,
	output logic [N_BLK-1:0]   ram_ext_o,
	output logic [N_BLK-1:0]   ram_ext_ro_o,

	output logic [TAPE_AW-1:0] mem_addr_o,
	output logic [TAPE_DW-1:0] mem_din_o,
	output logic               mem_we_o,
	output logic               mem_rd_o,
	output logic               fifo_wr_o,
	output logic [TAPE_DW-1:0] fifo_data_o,
	output logic               tape_play_o
);

	logic [CONF_AW-1:0] prg_addr;
	logic [CONF_DW-1:0] prg_data;
	logic               prg_wr;
	logic [CONF_AW-1:0] cart_addr;
	logic [CONF_DW-1:0] cart_data;
	logic               cart_wr;
	logic [N_BLK-1:0]   blk_mask;
	logic [2:0]         extram2_en;

	prg_loader u_prg (
		.clk_sys, .reset,
		.dl_active_i, .dl_index_i, .dl_wr_i, .dl_addr_i, .dl_data_i,
		.conf_addr_o (prg_addr),
		.conf_data_o (prg_data),
		.conf_wr_o   (prg_wr)
	);

	cart_rom_loader u_cart (
		.clk_sys, .reset,
		.dl_active_i, .dl_index_i, .dl_wr_i, .dl_addr_i, .dl_data_i, .dl_ext_i,
		.conf_addr_o (cart_addr),
		.conf_data_o (cart_data),
		.conf_wr_o   (cart_wr),
		.blk_mask_o  (blk_mask)
	);

	tape_streamer u_tape (
		.clk_sys, .reset,
		.dl_active_i, .dl_index_i, .dl_wr_i, .dl_addr_i, .dl_data_i, .dl_wait_o,
		.play_btn_i, .unload_i,
		.mem_addr_o, .mem_din_o, .mem_we_o, .mem_rd_o, .mem_dout_i, .mem_ready_i,
		.fifo_wr_o, .fifo_data_o, .fifo_full_i, .fifo_empty_i,
		.tape_play_o
	);

	////////////////////////////////////////////////////////////
	// Write bus merge of two loaders that never strobe together
	////////////////////////////////////////////////////////////
	assign conf_wr_o   = prg_wr | cart_wr;
	assign conf_addr_o = prg_wr ? prg_addr : cart_addr;
	assign conf_data_o = prg_wr ? prg_data : cart_data;

	// ExtRAM 2 grows upward from block 1
	always_comb begin
		case (extram2_sel_i)
			2'd0:    extram2_en = 3'b000;
			2'd1:    extram2_en = 3'b001;
			2'd2:    extram2_en = 3'b011;
			default: extram2_en = 3'b111;
		endcase
	end

	assign ram_ext_o    = {extram3_i, extram2_en, extram1_i} | blk_mask;
	assign ram_ext_ro_o = cart_writable_i ? '0 : blk_mask;

endmodule

//--- hdl/vic_map_pkg.sv
/*
 * Download indices, memory-map limits and BASIC end-pointer addresses
 * shared by the loaders and the top level
 */
package vic_map_pkg;

	////////////////////////////////////////////////////////////
	// Host download indices
	////////////////////////////////////////////////////////////
	localparam logic [7:0] IDX_ROM = 8'd0;
	localparam logic [7:0] IDX_PRG = 8'd1;
	localparam logic [7:0] IDX_CRT = 8'd2;
	localparam logic [7:0] IDX_CTX = 8'd3;
	localparam logic [7:0] IDX_TAP = 8'd5;

	////////////////////////////////////////////////////////////
	// Memory map
	////////////////////////////////////////////////////////////
	// PRG data stops at the start of the cartridge area
	localparam logic [15:0] PRG_LIMIT  = 16'hA000;
	// Cartridge data stops at the BASIC ROM
	localparam logic [15:0] CART_LIMIT = 16'hC000;

	// Accepted part of the system ROM image and its place in config space
	localparam logic [24:0] ROM_WIN_LO = 25'h4000;
	localparam logic [24:0] ROM_WIN_HI = 25'h8000;
	localparam logic [15:0] ROM_OFFSET = 16'h8000;

	// BASIC pointers patched after a PRG load take the low byte on even entries
	localparam logic [15:0] BASIC_PTRS [0:7] = '{
		16'h002D, 16'h002E,
		16'h002F, 16'h0030,
		16'h0031, 16'h0032,
		16'h00AE, 16'h00AF
	};

	// Configuration write bus
	localparam int CONF_AW = 16;
	localparam int CONF_DW = 8;

	// Blocks 0-3 cover 0000-7FFF in 8 KB steps and block 4 covers A000-BFFF
	localparam int N_BLK = 5;

endpackage

//--- sources.f
hdl/vic_map_pkg.sv
hdl/tape_pkg.sv
hdl/prg_loader.sv
hdl/cart_rom_loader.sv
hdl/tape_streamer.sv
hdl/vic_loader_top.sv
tb/vic_loader_props.sv
tb/tb_vic_loader.sv

//--- tb/tb_vic_loader.sv
/*
 * Testbench for the loader top level with core, memory and FIFO models
 */
`timescale 1ns/1ps

module tb_vic_loader;

	logic        clk_sys = 1'b0;
	logic        reset;
	logic        dl_active_i;
	logic [7:0]  dl_index_i;
	logic        dl_wr_i;
	logic [24:0] dl_addr_i;
	logic [7:0]  dl_data_i;
	logic [7:0]  dl_ext_i;
	logic        dl_wait_o;
	logic        play_btn_i;
	logic        unload_i;
	logic [7:0]  mem_dout_i;
	logic        mem_ready_i;
	logic        fifo_full_i;
	logic        fifo_empty_i;
	logic        extram1_i;
	logic [1:0]  extram2_sel_i;
	logic        extram3_i;
	logic        cart_writable_i;
	logic [15:0] conf_addr_o;
	logic [7:0]  conf_data_o;
	logic        conf_wr_o;
	logic [4:0]  ram_ext_o;
	logic [4:0]  ram_ext_ro_o;
	logic [24:0] mem_addr_o;
	logic [7:0]  mem_din_o;
	logic        mem_we_o;
	logic        mem_rd_o;
	logic        fifo_wr_o;
	logic [7:0]  fifo_data_o;
	logic        tape_play_o;

	integer      seed = 32'h1e06;
	logic [7:0]  img [0:65535];
	logic [7:0]  core_mem [int];
	logic [7:0]  exp_mem [int];
	logic [7:0]  tape_mem [int];
	logic [7:0]  fifo_q [$];
	logic [4:0]  exp_mask;
	logic        full_rand;
	int          busy;
	logic        rd_busy;
	logic [24:0] rd_addr;

	vic_loader_top dut0 (.*);

	always #50 clk_sys = ~clk_sys;

	// Unwritten tape memory reads back a pattern of the full address
	function automatic logic [7:0] fill_byte(input logic [24:0] a);
		return a[7:0] ^ a[15:8] ^ a[23:16] ^ {7'd0, a[24]} ^ 8'h5a;
	endfunction

	////////////////////////////////////////////////////////////
	// Core, memory and FIFO models
	////////////////////////////////////////////////////////////
	always @(negedge clk_sys) begin
		if (!reset && conf_wr_o)
			core_mem[conf_addr_o] = conf_data_o;
	end

	always @(negedge clk_sys) begin
		if (reset) begin
			mem_ready_i = 1'b1;
			busy        = 0;
			rd_busy     = 1'b0;
		end else if (mem_we_o) begin
			tape_mem[mem_addr_o] = mem_din_o;
			mem_ready_i = 1'b0;
			busy        = 1 + $unsigned($random(seed)) % 4;
		end else if (mem_rd_o) begin
			rd_addr     = mem_addr_o;
			rd_busy     = 1'b1;
			mem_ready_i = 1'b0;
			busy        = 1 + $unsigned($random(seed)) % 4;
		end else if (busy > 0) begin
			busy = busy - 1;
			if (busy == 0) begin
				if (rd_busy)
					mem_dout_i = tape_mem.exists(rd_addr) ? tape_mem[rd_addr] : fill_byte(rd_addr);
				rd_busy     = 1'b0;
				mem_ready_i = 1'b1;
			end
		end
	end

	always @(negedge clk_sys) begin
		if (fifo_wr_o)
			fifo_q.push_back(fifo_data_o);
		fifo_full_i = full_rand && ($unsigned($random(seed)) % 4 == 0);
	end

	////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////
	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("mismatch %s: got %h, expected %h", name, got, exp);
			$display("Simulation FAILED");
			$fatal(1);
		end
	endtask

	task automatic fail(input string msg);
		$display("%s", msg);
		$display("Simulation FAILED");
		$fatal(1);
	endtask

	task automatic check_core();
		compare("conf write count", core_mem.size(), exp_mem.size());
		foreach (exp_mem[a]) begin
			if (!core_mem.exists(a))
				fail($sformatf("no core write seen at address %h", a));
			compare($sformatf("conf_data_o @%h", a), core_mem[a], exp_mem[a]);
		end
		core_mem.delete();
		exp_mem.delete();
	endtask

	// One host download of img[0..n-1], holding off while the DUT waits
	task automatic host_load(input logic [7:0] idx, input logic [7:0] ext, input int n);
		int t;
		@(negedge clk_sys);
		dl_index_i  = idx;
		dl_ext_i    = ext;
		dl_addr_i   = '0;
		dl_active_i = 1'b1;
		for (int i = 0; i < n; i++) begin
			@(negedge clk_sys);
			t = 0;
			while (dl_wait_o) begin
				@(negedge clk_sys);
				t++;
				if (t > 50)
					fail("dl_wait_o stayed high during a download");
			end
			dl_addr_i = i;
			dl_data_i = img[i];
			dl_wr_i   = 1'b1;
			@(negedge clk_sys);
			dl_wr_i   = 1'b0;
		end
		t = 0;
		while (dl_wait_o) begin
			@(negedge clk_sys);
			t++;
			if (t > 50)
				fail("dl_wait_o stayed high after the last byte");
		end
		@(negedge clk_sys);
		dl_active_i = 1'b0;
		repeat (4) @(negedge clk_sys);
	endtask

	task automatic load_cart(input logic [7:0] idx, input logic [7:0] ext,
			input logic [15:0] base, input int n, input int skip);
		logic [15:0] a;
		for (int i = skip; i < n; i++)
			img[i] = $random(seed);
		a = base;
		for (int i = skip; i < n; i++) begin
			if (a < 16'hC000) begin
				exp_mem[a] = img[i];
				case (a[15:13])
					3'd0, 3'd1, 3'd2, 3'd3: exp_mask[a[15:13]] = 1'b1;
					3'd5: exp_mask[4] = 1'b1;
					default: ;
				endcase
				a = a + 16'd1;
			end
		end
		host_load(idx, ext, n);
		check_core();
	endtask

	task automatic check_masks(input int rounds);
		logic [2:0] e2;
		repeat (rounds) begin
			@(negedge clk_sys);
			{extram1_i, extram2_sel_i, extram3_i, cart_writable_i} = $random(seed);
			@(negedge clk_sys);
			e2 = (extram2_sel_i == 0) ? 3'b000 : (extram2_sel_i == 1) ? 3'b001 :
				(extram2_sel_i == 2) ? 3'b011 : 3'b111;
			compare("ram_ext_o", ram_ext_o, {extram3_i, e2, extram1_i} | exp_mask);
			compare("ram_ext_ro_o", ram_ext_ro_o, cart_writable_i ? 5'd0 : exp_mask);
		end
	endtask

	task automatic press_play();
		@(negedge clk_sys);
		play_btn_i = 1'b1;
		@(negedge clk_sys);
		play_btn_i = 1'b0;
	endtask

	////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////
	initial begin
		logic [15:0] base;
		logic [15:0] fin;
		logic [7:0]  ext;
		int          n;
		int          t;
		logic [7:0]  ptrs [0:7];

		ptrs = '{8'h2D, 8'h2E, 8'h2F, 8'h30, 8'h31, 8'h32, 8'hAE, 8'hAF};
		reset = 1'b1;
		{dl_active_i, dl_wr_i, play_btn_i, unload_i, fifo_empty_i} = '0;
		{dl_index_i, dl_addr_i, dl_data_i, dl_ext_i, mem_dout_i} = '0;
		{extram1_i, extram2_sel_i, extram3_i, cart_writable_i} = '0;
		mem_ready_i = 1'b1;
		fifo_full_i = 1'b0;
		full_rand   = 1'b0;
		exp_mask    = '0;
		repeat (4) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;
		compare("dl_wait_o", dl_wait_o, 0);
		compare("conf_wr_o", conf_wr_o, 0);

		// PRG near the top of RAM so some loads get clipped at A000
		n    = 3 + $unsigned($random(seed)) % 400;
		base = 16'h9E00 + $unsigned($random(seed)) % 16'h0300;
		img[0] = base[7:0];
		img[1] = base[15:8];
		fin = base;
		for (int i = 2; i < n; i++) begin
			img[i] = $random(seed);
			if (fin < 16'hA000) begin
				exp_mem[fin] = img[i];
				fin = fin + 16'd1;
			end
		end
		for (int i = 0; i < 8; i++)
			exp_mem[ptrs[i]] = i[0] ? fin[15:8] : fin[7:0];
		host_load(8'd1, 8'h00, n);
		t = 0;
		while (!core_mem.exists(16'h00AF)) begin
			@(negedge clk_sys);
			t++;
			if (t > 100)
				fail("BASIC pointer patch did not finish");
		end
		repeat (4) @(negedge clk_sys);
		check_core();

		// System ROM image
		n = 16'h3F80 + $unsigned($random(seed)) % 16'h4100;
		for (int i = 0; i < n; i++) begin
			img[i] = $random(seed);
			if (i >= 16'h4000 && i < 16'h8000)
				exp_mem[i + 16'h8000] = img[i];
		end
		host_load(8'd0, 8'h00, n);
		check_core();

		// CRT with header, then a CT? image
		base = {$unsigned($random(seed)) % 6, 13'h0} + $unsigned($random(seed)) % 16'h100;
		n    = 3 + $unsigned($random(seed)) % 700;
		img[0] = base[7:0];
		img[1] = base[15:8];
		load_cart(8'd2, 8'h00, base, n, 2);
		check_masks(4);
		t    = $unsigned($random(seed)) % 10;
		ext  = (t < 8) ? 8'h32 + t : 8'h41 + t - 8;
		base = (t < 8) ? (t + 2) * 16'h1000 : 16'hA000 + (t - 8) * 16'h1000;
		load_cart(8'd3, ext, base, 1 + $unsigned($random(seed)) % 700, 0);
		check_masks(4);

		// Tape image store and play
		n = 20 + $unsigned($random(seed)) % 180;
		for (int i = 0; i < n; i++)
			img[i] = $random(seed);
		full_rand = 1'b1;
		host_load(8'd5, 8'h00, n);
		for (int i = 0; i < n; i++)
			compare($sformatf("tape_mem @%h", i), tape_mem[i], img[i]);
		compare("tape_play_o", tape_play_o, 1);
		t = 0;
		while (fifo_q.size() < n / 2) begin
			@(negedge clk_sys);
			t++;
			if (t > 100 * n)
				fail("tape stream stalled before the play button test");
		end
		press_play();
		compare("tape_play_o", tape_play_o, 0);
		press_play();
		compare("tape_play_o", tape_play_o, 1);
		t = 0;
		while (fifo_q.size() < n + 1) begin
			@(negedge clk_sys);
			t++;
			if (t > 100 * n)
				fail("tape stream did not deliver the whole image");
		end
		repeat (20) @(negedge clk_sys);
		compare("FIFO byte count", fifo_q.size(), n + 1);
		for (int i = 0; i <= n; i++)
			compare($sformatf("fifo_data_o #%0d", i), fifo_q[i],
				(i < n) ? img[i] : fill_byte(i));
		full_rand = 1'b0;
		fifo_empty_i = 1'b1;
		@(negedge clk_sys);
		@(negedge clk_sys);
		compare("tape_play_o", tape_play_o, 0);
		fifo_empty_i = 1'b0;
		check_core();

		// Reset drops the cartridge blocks
		cart_writable_i = 1'b0;
		reset = 1'b1;
		repeat (4) @(negedge clk_sys);
		reset = 1'b0;
		exp_mask = '0;
		@(negedge clk_sys);
		compare("ram_ext_ro_o", ram_ext_ro_o, 0);
		compare("dl_wait_o", dl_wait_o, 0);
		check_masks(2);

		$display("Simulation PASSED");
		$finish;
	end

endmodule

//--- tb/vic_loader_props.sv
/*
 * Concurrent assertions on write strobes and the tape memory handshake
 */
`timescale 1ns/1ps

module vic_loader_props (
	input logic clk_sys,
	input logic reset,
	input logic wr_pulse,
	input logic mem_rd,
	input logic mem_we,
	input logic fifo_full
);

	// Write strobes are single-cycle pulses
	assert property (@(posedge clk_sys) disable iff (reset)
		wr_pulse |=> !wr_pulse)
		else $error("write strobe high for two cycles");

	assert property (@(posedge clk_sys) disable iff (reset)
		!(mem_rd && mem_we))
		else $error("mem_rd_o and mem_we_o high together");

	// A read starts from the cycle before, when the FIFO had room
	assert property (@(posedge clk_sys) disable iff (reset)
		mem_rd |-> !$past(fifo_full))
		else $error("tape read issued while the FIFO was full");

endmodule

bind vic_loader_top vic_loader_props u_props_top (
	.clk_sys   (clk_sys),
	.reset     (reset),
	.wr_pulse  (conf_wr_o),
	.mem_rd    (mem_rd_o),
	.mem_we    (mem_we_o),
	.fifo_full (fifo_full_i)
);

bind tape_streamer vic_loader_props u_props_tape (
	.clk_sys   (clk_sys),
	.reset     (reset),
	.wr_pulse  (fifo_wr_o),
	.mem_rd    (mem_rd_o),
	.mem_we    (mem_we_o),
	.fifo_full (fifo_full_i)
);
